/* design/cart_defs.svh */
/*
 * Cartridge loader shared constants
 * Widths of the download stream, mask and fill buses,
 * cheat storage depths and internal ROM header offsets
 */

`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// ==================================================
// Download stream and memory widths
// ==================================================
`define CART_ADDR_W       25
`define CART_DATA_W       16
`define CART_MASK_W       24
`define WRAM_FILL_W       17

// Cheat storage
`define CHEAT_SLOTS       8
`define CHEAT_FIFO_DEPTH  4

// ==================================================
// ROM header locations
// ==================================================
// Copier header in front of the image
`define COPIER_HDR        512
// Internal header base, RAM size byte sits at base + 2
`define LOROM_HDR_OFS     'h7FD6
`define HIROM_HDR_OFS     'hFFD6
`define EXHIROM_HDR_OFS   'h40FFD6

// Download index reserved for cheat codes
`define CODE_INDEX        8'hFF

`endif

/* design/cart_pkg.sv */
/*
 * Cartridge image types
 * User selections for header mapping, video region and
 * work-RAM fill, plus the decoded type and mask words
 */

package cart_pkg;

`include "cart_defs.svh"

	// ROM header selection
	typedef logic [2:0] map_sel_t;
	localparam map_sel_t MAP_AUTO    = 3'd0;
	localparam map_sel_t MAP_NONE    = 3'd1;
	localparam map_sel_t MAP_LOROM   = 3'd2;
	localparam map_sel_t MAP_HIROM   = 3'd3;
	localparam map_sel_t MAP_EXHIROM = 3'd4;

	// Video region selection, 2 and 3 both force PAL
	typedef logic [1:0] region_sel_t;
	localparam region_sel_t REGION_AUTO = 2'd0;
	localparam region_sel_t REGION_NTSC = 2'd1;

	// Initial work-RAM pattern
	typedef logic [1:0] fill_mode_t;
	localparam fill_mode_t FILL_9966 = 2'd0;
	localparam fill_mode_t FILL_00FF = 2'd1;
	localparam fill_mode_t FILL_55   = 2'd2;
	localparam fill_mode_t FILL_FF   = 2'd3;

	typedef logic [7:0]              rom_type_t;
	typedef logic [`CART_MASK_W-1:0] cart_mask_t;

endpackage

/* design/cheat_pkg.sv */
/*
 * Cheat code record types
 * A record arrives as eight download words and is used
 * as four 32-bit fields by the lookup
 */

package cheat_pkg;

`include "cart_defs.svh"

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} code_fields_t;

	typedef logic [7:0][`CART_DATA_W-1:0] code_words_t;

	// Same 128 bits, written by word and read by field
	typedef union packed {
		code_fields_t f;
		code_words_t  w;
	} cheat_code_t;

	// Flag bit enabling the compare check
	localparam int CMP_FLAG_BIT = 0;

	// Maps the download word number to its word inside the union
	// Order is flags, address, compare, replace, low half first
	function automatic logic [2:0] word_slot(input logic [2:0] sel);
		word_slot = {~sel[2:1], sel[0]};
	endfunction

endpackage

/* design/rom_header_detect.sv */
/*
 * ROM header detection
 * Watches the cartridge download for the size and type bytes
 * and produces the map type, ROM/RAM masks and video region
 */

`timescale 1ns/100ps
`include "cart_defs.svh"

module rom_header_detect (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    cart_load,
	input  logic                    dl_wr,
	input  logic [`CART_ADDR_W-1:0] dl_addr,
	input  logic [`CART_DATA_W-1:0] dl_data,
	input  cart_pkg::map_sel_t      map_sel,
	input  cart_pkg::region_sel_t   region_sel,
	output cart_pkg::rom_type_t     rom_type,
	output cart_pkg::cart_mask_t    rom_mask,
	output cart_pkg::cart_mask_t    ram_mask,
	output logic                    pal
);

	localparam int ADDR_W = `CART_ADDR_W;

	logic [3:0]          rom_size;
	logic [3:0]          ram_size;
	logic [3:0]          rom_size_nxt;
	logic [3:0]          ram_size_nxt;
	logic                region_bit;
	logic                hdr_en;
	logic [ADDR_W-1:0]   hdr_addr;
	cart_pkg::rom_type_t type_nxt;

	// Internal header location in the download, copier header included
	always_comb begin
		hdr_en   = 1'b1;
		hdr_addr = '0;
		case (map_sel)
			cart_pkg::MAP_LOROM:   hdr_addr = ADDR_W'(`LOROM_HDR_OFS + `COPIER_HDR);
			cart_pkg::MAP_HIROM:   hdr_addr = ADDR_W'(`HIROM_HDR_OFS + `COPIER_HDR);
			cart_pkg::MAP_EXHIROM: hdr_addr = ADDR_W'(`EXHIROM_HDR_OFS + `COPIER_HDR);
			default:               hdr_en   = 1'b0;
		endcase
	end

	// Size and type values after the current word
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		type_nxt     = rom_type;
		if (dl_addr == '0) begin
			rom_size_nxt = 4'hC;
			ram_size_nxt = 4'h0;
			if (map_sel == cart_pkg::MAP_AUTO && dl_data[7:0] != 8'd0)
				{ram_size_nxt, rom_size_nxt} = dl_data[7:0];
			case (map_sel)
				cart_pkg::MAP_NONE,
				cart_pkg::MAP_LOROM:   type_nxt = 8'd0;
				cart_pkg::MAP_HIROM:   type_nxt = 8'd1;
				cart_pkg::MAP_EXHIROM: type_nxt = 8'd2;
				default:               type_nxt = dl_data[15:8];
			endcase
		end
		if (hdr_en && dl_addr == hdr_addr)
			rom_size_nxt = dl_data[11:8];
		if (hdr_en && dl_addr == hdr_addr + ADDR_W'(2))
			ram_size_nxt = dl_data[3:0];
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= 4'hC;
			ram_size   <= 4'h0;
			region_bit <= 1'b0;
			rom_type   <= '0;
			rom_mask   <= '0;
			ram_mask   <= '0;
			pal        <= 1'b0;
		end else if (cart_load) begin
			if (dl_wr) begin
				rom_size <= rom_size_nxt;
				ram_size <= ram_size_nxt;
				rom_type <= type_nxt;
				if (dl_addr == ADDR_W'(2))
					region_bit <= dl_data[8];
				rom_mask <= (cart_pkg::cart_mask_t'(1024) << rom_size_nxt) - 1'b1;
				ram_mask <= (ram_size_nxt != 4'h0) ?
					(cart_pkg::cart_mask_t'(1024) << ram_size_nxt) - 1'b1 : '0;
			end
		end else begin
			// Region is only applied once the image is in
			case (region_sel)
				cart_pkg::REGION_AUTO: pal <= region_bit;
				cart_pkg::REGION_NTSC: pal <= 1'b0;
				default:               pal <= 1'b1;
			endcase
		end
	end

endmodule

/* design/wram_clear.sv */
/*
 * Work-RAM clear sequencer
 * Sweeps every work-RAM address once per cartridge load
 * and supplies the selected power-on fill pattern
 */

`timescale 1ns/100ps
`include "cart_defs.svh"

module wram_clear (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    cart_load,
	input  cart_pkg::fill_mode_t    fill_mode,
	output logic                    fill_busy,
	output logic                    fill_wr,
	output logic [`WRAM_FILL_W-1:0] fill_addr,
	output logic [7:0]              fill_data
);

	logic cart_load_d;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_load_d <= 1'b0;
			fill_busy   <= 1'b0;
			fill_addr   <= '0;
		end else begin
			cart_load_d <= cart_load;
			if (&fill_addr)
				fill_busy <= 1'b0;
			// New load start wins over the end of a sweep
			if (cart_load && !cart_load_d)
				fill_busy <= 1'b1;
			fill_addr <= fill_busy ? fill_addr + 1'b1 : '0;
		end
	end

	assign fill_wr = fill_busy;

	always_comb begin
		case (fill_mode)
			cart_pkg::FILL_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			cart_pkg::FILL_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			cart_pkg::FILL_55:   fill_data = 8'h55;
			cart_pkg::FILL_FF:   fill_data = 8'hFF;
			default:             fill_data = 8'h00;
		endcase
	end

endmodule

/* design/cheat_code_assembler.sv */
/*
 * Cheat code assembler
 * Gathers eight download words into one code record and
 * offers it to the FIFO with a valid/ready handshake
 */

`timescale 1ns/100ps
`include "cart_defs.svh"

module cheat_code_assembler (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    gg_reset,
	input  logic                    code_load,
	input  logic                    dl_wr,
	input  logic [`CART_ADDR_W-1:0] dl_addr,
	input  logic [`CART_DATA_W-1:0] dl_data,
	input  logic                    rec_ready,
	output logic                    rec_valid,
	output cheat_pkg::cheat_code_t  rec,
	output logic                    code_overflow
);

	cheat_pkg::cheat_code_t asm_buf;
	cheat_pkg::cheat_code_t asm_nxt;
	logic                   word_wr;
	logic                   last_word;
	logic                   slot_free;

	assign word_wr   = code_load && dl_wr;
	assign last_word = word_wr && dl_addr[3:1] == 3'd7;
	// Output register can take a new record this cycle
	assign slot_free = !rec_valid || rec_ready;

	always_comb begin
		asm_nxt = asm_buf;
		asm_nxt.w[cheat_pkg::word_slot(dl_addr[3:1])] = dl_data;
	end

	// Partial record, kept apart so a pending record stays stable
	always_ff @(posedge clk_sys) begin
		if (word_wr)
			asm_buf <= asm_nxt;
		if (last_word && slot_free)
			rec <= asm_nxt;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || gg_reset) begin
			rec_valid     <= 1'b0;
			code_overflow <= 1'b0;
		end else if (last_word) begin
			if (slot_free)
				rec_valid <= 1'b1;
			else
				code_overflow <= 1'b1;
		end else if (rec_ready) begin
			rec_valid <= 1'b0;
		end
	end

endmodule

/* design/cheat_fifo.sv */
/*
 * Cheat record FIFO
 * Circular buffer between the assembler and the cheat table
 */

`timescale 1ns/100ps
`include "cart_defs.svh"

module cheat_fifo (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   gg_reset,
	input  logic                   rec_valid,
	input  cheat_pkg::cheat_code_t rec,
	input  logic                   out_ready,
	output logic                   rec_ready,
	output logic                   out_valid,
	output cheat_pkg::cheat_code_t out_rec
);

	localparam int DEPTH = `CHEAT_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	cheat_pkg::cheat_code_t mem [DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [CNT_W-1:0]       count;
	logic                   push;
	logic                   pop;

	assign rec_ready = count != CNT_W'(DEPTH);
	assign out_valid = count != '0;
	assign out_rec   = mem[rd_ptr];

	assign push = rec_valid && rec_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= rec;
	end

	// ==================================================
	// Pointers and fill level
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET || gg_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

/* design/cheat_table.sv */
/*
 * Cheat code table
 * Holds loaded codes in slots and patches ROM read data
 * when the address and optional compare value match
 */

`timescale 1ns/100ps
`include "cart_defs.svh"

module cheat_table (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    gg_reset,
	input  logic                    gg_en,
	input  logic                    out_valid,
	input  cheat_pkg::cheat_code_t  out_rec,
	input  logic [`CART_MASK_W-1:0] rom_addr,
	input  logic [7:0]              rom_rdata,
	output logic                    out_ready,
	output logic [7:0]              rom_patched,
	output logic                    code_hit
);

	localparam int SLOTS  = `CHEAT_SLOTS;
	localparam int SLOT_W = $clog2(SLOTS);
	localparam int CNT_W  = $clog2(SLOTS + 1);

	cheat_pkg::cheat_code_t slots [SLOTS];
	logic [CNT_W-1:0]       used;
	logic                   load;

	assign out_ready = used != CNT_W'(SLOTS);
	assign load      = out_valid && out_ready;

	// Slots are filled in order, the next free one is at used
	always_ff @(posedge clk_sys) begin
		if (load)
			slots[used[SLOT_W-1:0]] <= out_rec;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || gg_reset)
			used <= '0;
		else if (load)
			used <= used + 1'b1;
	end

	// ==================================================
	// Lookup on the ROM read bus
	// ==================================================
	always_comb begin
		cheat_pkg::code_fields_t fld;
		logic                    cmp_ok;
		rom_patched = rom_rdata;
		code_hit    = 1'b0;
		// Walk downwards so the lowest matching slot is applied last
		for (int i = SLOTS - 1; i >= 0; i--) begin
			fld    = slots[i].f;
			cmp_ok = !fld.flags[cheat_pkg::CMP_FLAG_BIT] ||
				fld.compare[7:0] == rom_rdata;
			if (gg_en && CNT_W'(i) < used && fld.addr == 32'(rom_addr) && cmp_ok) begin
				rom_patched = fld.replace[7:0];
				code_hit    = 1'b1;
			end
		end
	end

endmodule

/* design/cart_loader_top.sv */
/*
 * Cartridge load front end
 * Splits the host download into cartridge and cheat traffic
 * and connects header detection, WRAM clear and cheat path
 */

`timescale 1ns/100ps
`include "cart_defs.svh"

module cart_loader_top (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    dl_active,
	input  logic [7:0]              dl_index,
	input  logic [`CART_ADDR_W-1:0] dl_addr,
	input  logic [`CART_DATA_W-1:0] dl_data,
	input  logic                    dl_wr,
	input  cart_pkg::map_sel_t      map_sel,
	input  cart_pkg::region_sel_t   region_sel,
	input  cart_pkg::fill_mode_t    fill_mode,
	input  logic                    gg_en,
	output cart_pkg::rom_type_t     rom_type,
	output cart_pkg::cart_mask_t    rom_mask,
	output cart_pkg::cart_mask_t    ram_mask,
	output logic                    pal,
	output logic                    fill_busy,
	output logic                    fill_wr,
	output logic [`WRAM_FILL_W-1:0] fill_addr,
	output logic [7:0]              fill_data,
	input  logic [`CART_MASK_W-1:0] rom_addr,
	input  logic [7:0]              rom_rdata,
	output logic [7:0]              rom_patched,
	output logic                    code_hit,
	output logic                    code_overflow
);

	logic                   cart_load;
	logic                   code_load;
	logic                   gg_reset;
	logic                   rec_valid;
	logic                   rec_ready;
	cheat_pkg::cheat_code_t rec;
	logic                   out_valid;
	logic                   out_ready;
	cheat_pkg::cheat_code_t out_rec;

	// Download kind, decoded once for every block
	assign cart_load = dl_active && dl_index != `CODE_INDEX;
	assign code_load = dl_active && dl_index == `CODE_INDEX;
	// Cheats are wiped by a new cartridge or the start of a code file
	assign gg_reset  = cart_load || (code_load && dl_wr && dl_addr == '0);

	rom_header_detect u_hdr (
		.clk_sys, .RESET, .cart_load, .dl_wr, .dl_addr, .dl_data,
		.map_sel, .region_sel, .rom_type, .rom_mask, .ram_mask, .pal
	);

	wram_clear u_wram (
		.clk_sys, .RESET, .cart_load, .fill_mode,
		.fill_busy, .fill_wr, .fill_addr, .fill_data
	);

	cheat_code_assembler u_asm (
		.clk_sys, .RESET, .gg_reset, .code_load, .dl_wr, .dl_addr, .dl_data,
		.rec_ready, .rec_valid, .rec, .code_overflow
	);

	cheat_fifo u_fifo (
		.clk_sys, .RESET, .gg_reset, .rec_valid, .rec, .out_ready,
		.rec_ready, .out_valid, .out_rec
	);

	cheat_table u_table (
		.clk_sys, .RESET, .gg_reset, .gg_en, .out_valid, .out_rec,
		.rom_addr, .rom_rdata, .out_ready, .rom_patched, .code_hit
	);

endmodule

/* verification/tb_cart_loader.sv */
/*
 * Cartridge loader testbench
 * Drives cartridge and cheat downloads into the loader, checks
 * header decoding, the work-RAM sweep and the cheat patch lookup
 */

`timescale 1ns/100ps
`include "cart_defs.svh"

module tb_cart_loader;

	localparam int TIMEOUT_CYCLES = 3 * (1 << `WRAM_FILL_W);
	localparam int FILL_WORDS     = 1 << `WRAM_FILL_W;
	localparam int MAX_CODES      = 16;

	typedef struct packed {
		cart_pkg::rom_type_t  rtype;
		cart_pkg::cart_mask_t rom;
		cart_pkg::cart_mask_t ram;
	} hdr_exp_t;

	logic                    clk_sys;
	logic                    RESET;
	logic                    dl_active;
	logic [7:0]              dl_index;
	logic [`CART_ADDR_W-1:0] dl_addr;
	logic [`CART_DATA_W-1:0] dl_data;
	logic                    dl_wr;
	cart_pkg::map_sel_t      map_sel;
	cart_pkg::region_sel_t   region_sel;
	cart_pkg::fill_mode_t    fill_mode;
	logic                    gg_en;
	cart_pkg::rom_type_t     rom_type;
	cart_pkg::cart_mask_t    rom_mask;
	cart_pkg::cart_mask_t    ram_mask;
	logic                    pal;
	logic                    fill_busy;
	logic                    fill_wr;
	logic [`WRAM_FILL_W-1:0] fill_addr;
	logic [7:0]              fill_data;
	logic [`CART_MASK_W-1:0] rom_addr;
	logic [7:0]              rom_rdata;
	logic [7:0]              rom_patched;
	logic                    code_hit;
	logic                    code_overflow;

	// Expected state written by the stimulus on falling edges
	integer      seed = 76;
	logic        chk_hdr;
	logic        chk_patch;
	hdr_exp_t    exp_hdr;
	logic        exp_pal;
	logic        exp_overflow;
	int          m_used;
	int          m_waiting;
	logic [31:0] code_flags [MAX_CODES];
	logic [31:0] code_addr  [MAX_CODES];
	logic [31:0] code_cmp   [MAX_CODES];
	logic [31:0] code_rep   [MAX_CODES];

	// Checker state
	int                      cycles = 0;
	int                      fill_count = 0;
	int                      fills_done = 0;
	logic                    fill_prev_busy = 1'b0;
	logic [`WRAM_FILL_W-1:0] fill_exp_addr;
	logic [8:0]              patch_exp;

	cart_loader_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Reference model
	// ==================================================
	function automatic cart_pkg::cart_mask_t size_mask(input logic [3:0] sz);
		logic [31:0] full;
		full = (32'd1024 << sz) - 32'd1;
		return full[`CART_MASK_W-1:0];
	endfunction

	function automatic hdr_exp_t expected_masks(input cart_pkg::map_sel_t m,
			input logic [15:0] w0, input logic [3:0] rom_hdr, input logic [3:0] ram_hdr);
		hdr_exp_t    e;
		logic [3:0]  rom_sz;
		logic [3:0]  ram_sz;
		rom_sz = 4'hC;
		ram_sz = 4'h0;
		if (m == cart_pkg::MAP_AUTO && w0[7:0] != 8'h00) begin
			rom_sz = w0[3:0];
			ram_sz = w0[7:4];
		end
		case (m)
			cart_pkg::MAP_AUTO:    e.rtype = w0[15:8];
			cart_pkg::MAP_HIROM:   e.rtype = 8'd1;
			cart_pkg::MAP_EXHIROM: e.rtype = 8'd2;
			default:               e.rtype = 8'd0;
		endcase
		// Internal header overrides the sizes from address 0
		if (m == cart_pkg::MAP_LOROM || m == cart_pkg::MAP_HIROM ||
				m == cart_pkg::MAP_EXHIROM) begin
			rom_sz = rom_hdr;
			ram_sz = ram_hdr;
		end
		e.rom = size_mask(rom_sz);
		e.ram = (ram_sz == 4'h0) ? '0 : size_mask(ram_sz);
		return e;
	endfunction

	function automatic logic expected_pal(input cart_pkg::region_sel_t rs, input logic rbit);
		if (rs == cart_pkg::REGION_AUTO)
			return rbit;
		return rs != cart_pkg::REGION_NTSC;
	endfunction

	function automatic logic [7:0] expected_fill_data(input logic [`WRAM_FILL_W-1:0] a,
			input cart_pkg::fill_mode_t mode);
		case (mode)
			cart_pkg::FILL_9966: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			cart_pkg::FILL_00FF: return (a[9] != a[0]) ? 8'hFF : 8'h00;
			cart_pkg::FILL_55:   return 8'h55;
			default:             return 8'hFF;
		endcase
	endfunction

	// Hit flag in bit 8 above the patched byte
	// The first loaded slot wins
	function automatic logic [8:0] expected_patch(input logic en, input logic [23:0] a,
			input logic [7:0] d);
		logic [8:0] res;
		int         i;
		res = {1'b0, d};
		for (i = 0; i < m_used; i++) begin
			if (!res[8] && en && code_addr[i] == {8'h00, a} &&
					(!code_flags[i][cheat_pkg::CMP_FLAG_BIT] || code_cmp[i][7:0] == d))
				res = {1'b1, code_rep[i][7:0]};
		end
		return res;
	endfunction

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic abort_run;
		$display("** FAIL **");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_mask(input string name, input cart_pkg::cart_mask_t got,
			input cart_pkg::cart_mask_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_type(input string name, input cart_pkg::rom_type_t got,
			input cart_pkg::rom_type_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [`WRAM_FILL_W-1:0] got,
			input logic [`WRAM_FILL_W-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// ==================================================
	// Checker on each rising edge
	// ==================================================
	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			abort_run();
		end
		if (!RESET) begin
			if (chk_hdr) begin
				check_type("rom_type", rom_type, exp_hdr.rtype);
				check_mask("rom_mask", rom_mask, exp_hdr.rom);
				check_mask("ram_mask", ram_mask, exp_hdr.ram);
				check_bit("pal", pal, exp_pal);
			end
			if (chk_patch) begin
				patch_exp = expected_patch(gg_en, rom_addr, rom_rdata);
				check_byte("rom_patched", rom_patched, patch_exp[7:0]);
				check_bit("code_hit", code_hit, patch_exp[8]);
				check_bit("code_overflow", code_overflow, exp_overflow);
			end
			// Sweep must start at 0 and step by one
			if (fill_busy) begin
				fill_exp_addr = `WRAM_FILL_W'(fill_count);
				check_bit("fill_wr", fill_wr, 1'b1);
				check_addr("fill_addr", fill_addr, fill_exp_addr);
				check_byte("fill_data", fill_data, expected_fill_data(fill_exp_addr, fill_mode));
				fill_count++;
			end else begin
				check_bit("fill_wr", fill_wr, 1'b0);
				if (fill_prev_busy) begin
					if (fill_count != FILL_WORDS) begin
						$display("Work-RAM sweep ended after %0d writes instead of %0d",
							fill_count, FILL_WORDS);
						abort_run();
					end
					fills_done++;
					fill_count = 0;
				end
			end
			fill_prev_busy = fill_busy;
		end
	end

	// ==================================================
	// Stimulus tasks
	// ==================================================
	task automatic write_word(input logic [`CART_ADDR_W-1:0] a, input logic [15:0] d);
		@(negedge clk_sys);
		dl_addr = a;
		dl_data = d;
		dl_wr   = 1'b1;
	endtask

	task automatic end_stream;
		@(negedge clk_sys);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
	endtask

	function automatic logic [`CART_ADDR_W-1:0] header_addr(input cart_pkg::map_sel_t m);
		case (m)
			cart_pkg::MAP_LOROM:   return `CART_ADDR_W'(`LOROM_HDR_OFS + `COPIER_HDR);
			cart_pkg::MAP_HIROM:   return `CART_ADDR_W'(`HIROM_HDR_OFS + `COPIER_HDR);
			default:               return `CART_ADDR_W'(`EXHIROM_HDR_OFS + `COPIER_HDR);
		endcase
	endfunction

	// Header stream followed by a pal check for every region selection
	task automatic cart_download(input cart_pkg::map_sel_t m);
		logic [31:0]             r;
		logic [15:0]             w0;
		logic [3:0]              rom_hdr;
		logic [3:0]              ram_hdr;
		logic                    rbit;
		logic [`CART_ADDR_W-1:0] base;
		int                      rs;
		r       = $random(seed);
		w0      = r[15:0];
		rom_hdr = r[19:16];
		ram_hdr = r[23:20];
		rbit    = r[24];
		@(negedge clk_sys);
		chk_hdr   = 1'b0;
		chk_patch = 1'b0;
		map_sel   = m;
		dl_index  = {1'b0, r[31:25]};
		dl_active = 1'b1;
		write_word('0, w0);
		write_word(`CART_ADDR_W'(2), {r[31:25], rbit, r[7:0]});
		if (m == cart_pkg::MAP_LOROM || m == cart_pkg::MAP_HIROM ||
				m == cart_pkg::MAP_EXHIROM) begin
			base = header_addr(m);
			write_word(base, {r[15:12], rom_hdr, r[7:0]});
			write_word(base + `CART_ADDR_W'(2), {r[15:4], ram_hdr});
		end
		end_stream();
		exp_hdr = expected_masks(m, w0, rom_hdr, ram_hdr);
		// A cartridge load also wipes the cheat table
		m_used       = 0;
		m_waiting    = 0;
		exp_overflow = 1'b0;
		for (rs = 0; rs < 4; rs++) begin
			@(negedge clk_sys);
			region_sel = cart_pkg::region_sel_t'(rs);
			chk_hdr    = 1'b0;
			repeat (2) @(negedge clk_sys);
			exp_pal = expected_pal(region_sel, rbit);
			chk_hdr = 1'b1;
			repeat (2) @(negedge clk_sys);
		end
	endtask

	// Loads codes first to first+n-1
	// Code 0 sits at address 0 and resets the cheats
	task automatic code_download(input int first, input int n);
		logic [31:0]  r;
		logic [127:0] bits;
		int           k;
		int           j;
		@(negedge clk_sys);
		chk_patch = 1'b0;
		dl_index  = `CODE_INDEX;
		dl_active = 1'b1;
		for (k = first; k < first + n; k++) begin
			r = $random(seed);
			code_flags[k] = {r[31:1], k[0]};
			r = $random(seed);
			code_addr[k] = {8'h00, r[23:0]};
			code_cmp[k]  = $random(seed);
			code_rep[k]  = $random(seed);
			if (k == 0) begin
				m_used       = 0;
				m_waiting    = 0;
				exp_overflow = 1'b0;
			end
			bits = {code_rep[k], code_cmp[k], code_addr[k], code_flags[k]};
			for (j = 0; j < 8; j++)
				write_word(`CART_ADDR_W'(k * 16 + j * 2), bits[16 * j +: 16]);
			if (m_used < `CHEAT_SLOTS)
				m_used++;
			else if (m_waiting < `CHEAT_FIFO_DEPTH + 1)
				m_waiting++;
			else
				exp_overflow = 1'b1;
		end
		end_stream();
		// Assembler, FIFO and table each add one cycle
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic lookup(input logic [23:0] a, input logic [7:0] d, input logic en);
		@(negedge clk_sys);
		rom_addr  = a;
		rom_rdata = d;
		gg_en     = en;
		chk_patch = 1'b1;
	endtask

	task automatic random_lookups(input int n);
		logic [31:0] r;
		int          i;
		for (i = 0; i < n; i++) begin
			r = $random(seed);
			lookup(r[23:0], r[31:24], 1'b1);
		end
	endtask

	task automatic check_codes(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			lookup(code_addr[i][23:0], code_cmp[i][7:0], 1'b1);
			lookup(code_addr[i][23:0], code_cmp[i][7:0] ^ 8'h01, 1'b1);
			lookup(code_addr[i][23:0], code_cmp[i][7:0], 1'b0);
		end
		random_lookups(6);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		int i;
		RESET        = 1'b1;
		dl_active    = 1'b0;
		dl_index     = '0;
		dl_addr      = '0;
		dl_data      = '0;
		dl_wr        = 1'b0;
		map_sel      = cart_pkg::MAP_AUTO;
		region_sel   = cart_pkg::REGION_AUTO;
		fill_mode    = cart_pkg::FILL_9966;
		gg_en        = 1'b0;
		rom_addr     = '0;
		rom_rdata    = '0;
		chk_hdr      = 1'b0;
		chk_patch    = 1'b0;
		exp_hdr      = '0;
		exp_pal      = 1'b0;
		exp_overflow = 1'b0;
		m_used       = 0;
		m_waiting    = 0;
		repeat (4) @(negedge clk_sys);
		RESET = 1'b0;

		// Table starts empty
		random_lookups(4);

		for (i = 0; i <= 4; i++)
			cart_download(cart_pkg::map_sel_t'(i));

		// Run the sweep to its end while stepping through the fill patterns
		i = 0;
		while (fills_done == 0) begin
			@(negedge clk_sys);
			i++;
			if (i % 4096 == 0)
				fill_mode = cart_pkg::fill_mode_t'(fill_mode + 2'd1);
		end

		code_download(0, 6);
		check_codes(6);

		// Fill table and FIFO, leave one record pending, then overflow
		code_download(0, `CHEAT_SLOTS + `CHEAT_FIFO_DEPTH + 1);
		check_codes(`CHEAT_SLOTS + `CHEAT_FIFO_DEPTH + 1);
		code_download(`CHEAT_SLOTS + `CHEAT_FIFO_DEPTH + 1, 1);
		check_codes(`CHEAT_SLOTS + `CHEAT_FIFO_DEPTH + 2);

		// New code file clears everything
		code_download(0, 1);
		check_codes(`CHEAT_SLOTS + `CHEAT_FIFO_DEPTH + 2);

		@(negedge clk_sys);
		$display("** PASS **");
		$finish;
	end

endmodule

/* compile.f */
+incdir+design
design/cart_pkg.sv
design/cheat_pkg.sv
design/rom_header_detect.sv
design/wram_clear.sv
design/cheat_code_assembler.sv
design/cheat_fifo.sv
design/cheat_table.sv
design/cart_loader_top.sv
verification/tb_cart_loader.sv

/* Makefile */
# Verilator simulation of the cartridge loader testbench

TOP := tb_cart_loader

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir
